//--- hw/nkmd_pkg.sv
`default_nettype none

package nkmd_pkg;

    localparam int DATA_W = 32;
    localparam int REG_SEL_W = 4;

    // Selects with fixed meaning
    localparam logic [REG_SEL_W-1:0] REG_ZERO = 4'd0;
    localparam logic [REG_SEL_W-1:0] REG_RA = 4'd11;
    localparam logic [REG_SEL_W-1:0] REG_N = 4'd14;
    localparam logic [REG_SEL_W-1:0] REG_PC = 4'd15;

    // Instruction word layout
    localparam int JMP_BIT = 31;
    localparam int MW_LSB = 29;
    localparam int MW_W = 2;
    localparam int TREAD_BIT = 28;
    localparam int RD_LSB = 24;
    localparam int ALU_LSB = 21;
    localparam int ALU_W = 3;
    localparam int RS_LSB = 17;
    localparam int IMM_EN_BIT = 16;
    localparam int SIGN_BIT = 15;
    localparam int IMM_W = 15;
    localparam int REPN_BIT = 12;
    localparam int RT_LSB = 8;
    localparam int JREL_W = 8;

    // RESV, CLAMP and MUL give zero
    typedef enum logic [ALU_W-1:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        OR = 3'd2,
        AND = 3'd3,
        XOR = 3'd4,
        RESV = 3'd5,
        CLAMP = 3'd6,
        MUL = 3'd7
    } alu_op_e;

    typedef enum logic [MW_W-1:0] {
        MW_NONE = 2'd0,
        MW_R = 2'd1
    } mw_sel_e;

    localparam logic [DATA_W-1:0] RESET_PC = 32'h0;

endpackage

`default_nettype wire

//--- hw/nkmd_fetch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_fetch_decode #(
    parameter logic [nkmd_pkg::DATA_W-1:0] RESET_PC = nkmd_pkg::RESET_PC
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [nkmd_pkg::DATA_W-1:0]    p_data_i,
    input  logic                           jmp_en_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    jmp_pc_i,
    input  logic                           hold_i,
    output logic [nkmd_pkg::DATA_W-1:0]    p_addr_o,
    output logic [nkmd_pkg::REG_SEL_W-1:0] rs_sel_o,
    output logic [nkmd_pkg::REG_SEL_W-1:0] rt_sel_o,
    output logic [nkmd_pkg::REG_SEL_W-1:0] rd_sel_o,
    output nkmd_pkg::alu_op_e              alu_op_o,
    output logic [nkmd_pkg::DATA_W-1:0]    imm_o,
    output logic                           imm_en_o,
    output logic [nkmd_pkg::DATA_W-1:0]    jrel_o,
    output logic                           tread_o,
    output nkmd_pkg::mw_sel_e              mw_o,
    output logic                           jmp_o,
    output logic                           repn_o
);

    logic [nkmd_pkg::DATA_W-1:0] pc_q;
    logic rst_d_q;
    logic inst_jmp;
    logic inst_imm_en;
    logic sign;

    assign p_addr_o = pc_q;
    assign inst_jmp = p_data_i[nkmd_pkg::JMP_BIT];
    assign inst_imm_en = p_data_i[nkmd_pkg::IMM_EN_BIT];
    assign sign = p_data_i[nkmd_pkg::SIGN_BIT];

    // First word stays on the bus through the cleared decode cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (jmp_en_i) begin
            pc_q <= jmp_pc_i;
        end else if (!hold_i && !rst_d_q) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    // Keeps decode cleared one cycle past reset
    always_ff @(posedge clk) begin
        rst_d_q <= rst;
    end

    always_ff @(posedge clk) begin
        if (rst || rst_d_q) begin
            rs_sel_o <= nkmd_pkg::REG_ZERO;
            rt_sel_o <= nkmd_pkg::REG_ZERO;
            rd_sel_o <= nkmd_pkg::REG_ZERO;
            alu_op_o <= nkmd_pkg::ADD;
            imm_o <= '0;
            imm_en_o <= 1'b0;
            jrel_o <= '0;
            tread_o <= 1'b0;
            mw_o <= nkmd_pkg::MW_NONE;
            jmp_o <= 1'b0;
            repn_o <= 1'b0;
        end else if (!hold_i) begin
            rs_sel_o <= p_data_i[nkmd_pkg::RS_LSB +: nkmd_pkg::REG_SEL_W];
            rt_sel_o <= p_data_i[nkmd_pkg::RT_LSB +: nkmd_pkg::REG_SEL_W];
            rd_sel_o <= p_data_i[nkmd_pkg::RD_LSB +: nkmd_pkg::REG_SEL_W];
            alu_op_o <= nkmd_pkg::alu_op_e'(p_data_i[nkmd_pkg::ALU_LSB +: nkmd_pkg::ALU_W]);
            imm_o <= {{(nkmd_pkg::DATA_W - nkmd_pkg::IMM_W){sign}},
                      p_data_i[nkmd_pkg::IMM_W-1:0]};
            imm_en_o <= inst_imm_en;
            jrel_o <= {{(nkmd_pkg::DATA_W - nkmd_pkg::JREL_W){sign}},
                       p_data_i[nkmd_pkg::JREL_W-1:0]};
            tread_o <= !inst_jmp && p_data_i[nkmd_pkg::TREAD_BIT];
            // Codes 2 and 3 fall back to no store
            if (!inst_jmp && p_data_i[nkmd_pkg::MW_LSB +: nkmd_pkg::MW_W] == nkmd_pkg::MW_R) begin
                mw_o <= nkmd_pkg::MW_R;
            end else begin
                mw_o <= nkmd_pkg::MW_NONE;
            end
            jmp_o <= inst_jmp;
            repn_o <= !inst_jmp && !inst_imm_en && p_data_i[nkmd_pkg::REPN_BIT];
        end
    end

endmodule

`default_nettype wire

//--- hw/nkmd_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_regfile (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [nkmd_pkg::REG_SEL_W-1:0] rs_sel_i,
    input  logic [nkmd_pkg::REG_SEL_W-1:0] rt_sel_i,
    input  logic [nkmd_pkg::REG_SEL_W-1:0] rd_sel_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    n_val_i,
    input  logic [nkmd_pkg::REG_SEL_W-1:0] wb_sel_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    wb_val_i,
    output logic [nkmd_pkg::DATA_W-1:0]    rs_val_o,
    output logic [nkmd_pkg::DATA_W-1:0]    rt_val_o,
    output logic [nkmd_pkg::DATA_W-1:0]    rd_val_o
);

    // a..j at 1..10, sl and sh at 12 and 13; slot 11 is ra and stays zero
    logic [nkmd_pkg::DATA_W-1:0] gpr_q [1:13];
    logic wb_en;

    function automatic logic [nkmd_pkg::DATA_W-1:0] read_sel(
        input logic [nkmd_pkg::REG_SEL_W-1:0] sel
    );
        logic [nkmd_pkg::DATA_W-1:0] val;
        case (sel)
            nkmd_pkg::REG_ZERO, nkmd_pkg::REG_RA, nkmd_pkg::REG_PC: val = '0;
            nkmd_pkg::REG_N: val = n_val_i;
            default: val = gpr_q[sel];
        endcase
        return val;
    endfunction

    always_comb begin
        rs_val_o = read_sel(rs_sel_i);
        rt_val_o = read_sel(rt_sel_i);
        rd_val_o = read_sel(rd_sel_i);
    end

    // n lives in the repeat counter
    assign wb_en = wb_sel_i != nkmd_pkg::REG_ZERO
                   && wb_sel_i != nkmd_pkg::REG_RA
                   && wb_sel_i < nkmd_pkg::REG_N;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= 13; i++) begin
                gpr_q[i] <= '0;
            end
        end else if (wb_en) begin
            gpr_q[wb_sel_i] <= wb_val_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/nkmd_repeat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_repeat_counter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           repn_i,
    input  logic [nkmd_pkg::REG_SEL_W-1:0] wb_sel_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    wb_val_i,
    output logic [nkmd_pkg::DATA_W-1:0]    n_val_o,
    output logic                           hold_o
);

    logic [nkmd_pkg::DATA_W-1:0] n_q;
    logic n_zero_q;

    assign n_val_o = n_q;
    // Stall while a repeat is decoded and the count is not used up
    assign hold_o = repn_i && !n_zero_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            n_q <= '0;
            n_zero_q <= 1'b1;
        end else if (wb_sel_i == nkmd_pkg::REG_N) begin
            n_q <= wb_val_i;
            n_zero_q <= (wb_val_i == '0);
        end else if (hold_o) begin
            n_q <= n_q - 1'b1;
            n_zero_q <= (n_q == 1);
        end
    end

endmodule

`default_nettype wire

//--- hw/nkmd_operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_operand_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [nkmd_pkg::DATA_W-1:0]    rs_val_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    rt_val_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    rd_val_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    imm_i,
    input  logic                           imm_en_i,
    input  logic                           tread_i,
    input  nkmd_pkg::alu_op_e              alu_op_i,
    input  logic [nkmd_pkg::REG_SEL_W-1:0] rd_sel_i,
    input  nkmd_pkg::mw_sel_e              mw_i,
    input  logic                           jmp_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    jrel_i,
    input  logic                           st_en_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    st_addr_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    st_data_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    r_data_i,
    output logic [nkmd_pkg::DATA_W-1:0]    r_addr_o,
    output logic [nkmd_pkg::DATA_W-1:0]    r_data_o,
    output logic                           r_we_o,
    output logic [nkmd_pkg::DATA_W-1:0]    s_val_o,
    output logic [nkmd_pkg::DATA_W-1:0]    t_val_o,
    output nkmd_pkg::alu_op_e              alu_op_o,
    output logic [nkmd_pkg::REG_SEL_W-1:0] rd_sel_o,
    output logic [nkmd_pkg::DATA_W-1:0]    rd_val_o,
    output nkmd_pkg::mw_sel_e              mw_o,
    output logic                           jmp_o,
    output logic [nkmd_pkg::DATA_W-1:0]    jrel_o
);

    logic [nkmd_pkg::DATA_W-1:0] t_addr;
    logic [nkmd_pkg::DATA_W-1:0] t_addr_q;
    logic tread_q;

    assign t_addr = imm_en_i ? imm_i : rt_val_i;

    // Store from writeback owns the address lines
    assign r_addr_o = st_en_i ? st_addr_i : t_addr;
    assign r_data_o = st_data_i;
    assign r_we_o = st_en_i;

    // RAM data arrives one cycle after the address
    assign t_val_o = tread_q ? r_data_i : t_addr_q;

    always_ff @(posedge clk) begin
        s_val_o <= rs_val_i;
        t_addr_q <= t_addr;
        rd_val_o <= rd_val_i;
        jrel_o <= jrel_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tread_q <= 1'b0;
            alu_op_o <= nkmd_pkg::ADD;
            rd_sel_o <= nkmd_pkg::REG_ZERO;
            mw_o <= nkmd_pkg::MW_NONE;
            jmp_o <= 1'b0;
        end else begin
            tread_q <= tread_i;
            alu_op_o <= alu_op_i;
            rd_sel_o <= rd_sel_i;
            mw_o <= mw_i;
            jmp_o <= jmp_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/nkmd_execute.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_execute (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [nkmd_pkg::DATA_W-1:0]    s_val_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    t_val_i,
    input  nkmd_pkg::alu_op_e              alu_op_i,
    input  logic [nkmd_pkg::REG_SEL_W-1:0] rd_sel_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    rd_val_i,
    input  nkmd_pkg::mw_sel_e              mw_i,
    input  logic                           jmp_i,
    input  logic [nkmd_pkg::DATA_W-1:0]    jrel_i,
    output logic [nkmd_pkg::REG_SEL_W-1:0] wb_sel_o,
    output logic [nkmd_pkg::DATA_W-1:0]    wb_val_o,
    output logic                           st_en_o,
    output logic [nkmd_pkg::DATA_W-1:0]    st_addr_o,
    output logic [nkmd_pkg::DATA_W-1:0]    st_data_o,
    output logic                           jmp_en_o,
    output logic [nkmd_pkg::DATA_W-1:0]    jmp_pc_o
);

    logic [nkmd_pkg::DATA_W-1:0] alu_res;
    logic [nkmd_pkg::DATA_W-1:0] res_q;
    logic [nkmd_pkg::DATA_W-1:0] rd_val_q;
    logic [nkmd_pkg::REG_SEL_W-1:0] rd_sel_q;
    nkmd_pkg::mw_sel_e mw_q;

    always_comb begin
        case (alu_op_i)
            nkmd_pkg::ADD: alu_res = s_val_i + t_val_i;
            nkmd_pkg::SUB: alu_res = s_val_i - t_val_i;
            nkmd_pkg::OR: alu_res = s_val_i | t_val_i;
            nkmd_pkg::AND: alu_res = s_val_i & t_val_i;
            nkmd_pkg::XOR: alu_res = s_val_i ^ t_val_i;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        res_q <= alu_res;
        rd_val_q <= rd_val_i;
        jmp_pc_o <= rd_val_i + jrel_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_sel_q <= nkmd_pkg::REG_ZERO;
            mw_q <= nkmd_pkg::MW_NONE;
            jmp_en_o <= 1'b0;
        end else begin
            rd_sel_q <= rd_sel_i;
            mw_q <= mw_i;
            jmp_en_o <= jmp_i;
        end
    end

    // A store suppresses the register write
    assign st_en_o = (mw_q == nkmd_pkg::MW_R);
    assign st_addr_o = rd_val_q;
    assign st_data_o = res_q;
    assign wb_sel_o = st_en_o ? nkmd_pkg::REG_ZERO : rd_sel_q;
    assign wb_val_o = res_q;

endmodule

`default_nettype wire

//--- hw/nkmd_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu #(
    parameter logic [nkmd_pkg::DATA_W-1:0] RESET_PC = nkmd_pkg::RESET_PC
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [nkmd_pkg::DATA_W-1:0] p_data_i,
    output logic [nkmd_pkg::DATA_W-1:0] p_addr_o,
    input  logic [nkmd_pkg::DATA_W-1:0] r_data_i,
    output logic [nkmd_pkg::DATA_W-1:0] r_data_o,
    output logic [nkmd_pkg::DATA_W-1:0] r_addr_o,
    output logic                        r_we_o
);

    // Decode outputs
    logic [nkmd_pkg::REG_SEL_W-1:0] rs_sel, rt_sel, rd_sel;
    nkmd_pkg::alu_op_e dcd_alu_op;
    logic [nkmd_pkg::DATA_W-1:0] imm, dcd_jrel;
    logic imm_en, tread, dcd_jmp, repn;
    nkmd_pkg::mw_sel_e dcd_mw;

    // Register file and repeat counter
    logic [nkmd_pkg::DATA_W-1:0] rs_val, rt_val, dcd_rd_val, n_val;
    logic hold;

    // Operand stage outputs
    logic [nkmd_pkg::DATA_W-1:0] s_val, t_val, op_rd_val, op_jrel;
    nkmd_pkg::alu_op_e op_alu_op;
    logic [nkmd_pkg::REG_SEL_W-1:0] op_rd_sel;
    nkmd_pkg::mw_sel_e op_mw;
    logic op_jmp;

    // Writeback, store and jump
    logic [nkmd_pkg::REG_SEL_W-1:0] wb_sel;
    logic [nkmd_pkg::DATA_W-1:0] wb_val, st_addr, st_data, jmp_pc;
    logic st_en, jmp_en;

    nkmd_fetch_decode #(.RESET_PC(RESET_PC)) fetch_decode_inst (
        .clk(clk), .rst(rst),
        .p_data_i(p_data_i), .jmp_en_i(jmp_en), .jmp_pc_i(jmp_pc), .hold_i(hold),
        .p_addr_o(p_addr_o),
        .rs_sel_o(rs_sel), .rt_sel_o(rt_sel), .rd_sel_o(rd_sel),
        .alu_op_o(dcd_alu_op), .imm_o(imm), .imm_en_o(imm_en), .jrel_o(dcd_jrel),
        .tread_o(tread), .mw_o(dcd_mw), .jmp_o(dcd_jmp), .repn_o(repn)
    );

    nkmd_regfile regfile_inst (
        .clk(clk), .rst(rst),
        .rs_sel_i(rs_sel), .rt_sel_i(rt_sel), .rd_sel_i(rd_sel), .n_val_i(n_val),
        .wb_sel_i(wb_sel), .wb_val_i(wb_val),
        .rs_val_o(rs_val), .rt_val_o(rt_val), .rd_val_o(dcd_rd_val)
    );

    nkmd_repeat_counter repeat_counter_inst (
        .clk(clk), .rst(rst),
        .repn_i(repn), .wb_sel_i(wb_sel), .wb_val_i(wb_val),
        .n_val_o(n_val), .hold_o(hold)
    );

    nkmd_operand_stage operand_stage_inst (
        .clk(clk), .rst(rst),
        .rs_val_i(rs_val), .rt_val_i(rt_val), .rd_val_i(dcd_rd_val),
        .imm_i(imm), .imm_en_i(imm_en), .tread_i(tread), .alu_op_i(dcd_alu_op),
        .rd_sel_i(rd_sel), .mw_i(dcd_mw), .jmp_i(dcd_jmp), .jrel_i(dcd_jrel),
        .st_en_i(st_en), .st_addr_i(st_addr), .st_data_i(st_data),
        .r_data_i(r_data_i), .r_addr_o(r_addr_o), .r_data_o(r_data_o), .r_we_o(r_we_o),
        .s_val_o(s_val), .t_val_o(t_val), .alu_op_o(op_alu_op),
        .rd_sel_o(op_rd_sel), .rd_val_o(op_rd_val), .mw_o(op_mw),
        .jmp_o(op_jmp), .jrel_o(op_jrel)
    );

    nkmd_execute execute_inst (
        .clk(clk), .rst(rst),
        .s_val_i(s_val), .t_val_i(t_val), .alu_op_i(op_alu_op),
        .rd_sel_i(op_rd_sel), .rd_val_i(op_rd_val), .mw_i(op_mw),
        .jmp_i(op_jmp), .jrel_i(op_jrel),
        .wb_sel_o(wb_sel), .wb_val_o(wb_val),
        .st_en_o(st_en), .st_addr_o(st_addr), .st_data_o(st_data),
        .jmp_en_o(jmp_en), .jmp_pc_o(jmp_pc)
    );

endmodule

`default_nettype wire

//--- bench/nkmd_cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_asserts (
    input logic                        clk,
    input logic                        rst,
    input logic                        hold_i,
    input logic [nkmd_pkg::DATA_W-1:0] n_val_i,
    input logic [nkmd_pkg::DATA_W-1:0] p_addr_i,
    input logic                        r_we_i
);

    int fail_count = 0;

    // Pipeline comes out of reset holding no-ops
    no_store_after_reset: assert property (@(posedge clk) rst |=> !r_we_i)
        else begin
            fail_count++;
            $error("store strobe high during reset or in the cycle after it");
        end

    // A held fetch keeps its address
    pc_frozen_on_hold: assert property (
        @(posedge clk) disable iff (rst) hold_i |=> $stable(p_addr_i)
    ) else begin
        fail_count++;
        $error("program address moved while the repeat held the fetch");
    end

    hold_needs_count: assert property (
        @(posedge clk) disable iff (rst) hold_i |-> n_val_i != '0
    ) else begin
        fail_count++;
        $error("repeat hold active with a zero count");
    end

endmodule

`default_nettype wire

//--- bench/nkmd_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_tb;

    // Golden image layout, in words
    localparam int RAM_BASE = 'h40;
    localparam int RAM_WORDS = 16;
    localparam int INFO_BASE = 'h50;
    localparam int STORE_BASE = 'h52;
    localparam int STORE_TIMEOUT = 500;
    localparam int DRAIN_CYCLES = 16;
    localparam int TEST_COUNT = 5;

    logic clk;
    logic rst;
    logic [nkmd_pkg::DATA_W-1:0] p_addr;
    logic [nkmd_pkg::DATA_W-1:0] p_data;
    logic [nkmd_pkg::DATA_W-1:0] r_addr;
    logic [nkmd_pkg::DATA_W-1:0] r_wdata;
    logic [nkmd_pkg::DATA_W-1:0] r_rdata;
    logic r_we;

    logic [nkmd_pkg::DATA_W-1:0] golden [0:255];
    logic [nkmd_pkg::DATA_W-1:0] ram [0:RAM_WORDS-1];
    logic [nkmd_pkg::DATA_W-1:0] prog_len;
    int store_cnt;
    int store_idx;
    int entry;
    int cur_test;
    int cycles;
    int errors;
    int tests_passed;
    int tests_failed;
    int test_errors [1:TEST_COUNT];

    nkmd_cpu #(.RESET_PC(nkmd_pkg::RESET_PC)) nkmd_cpu_inst (
        .clk(clk), .rst(rst),
        .p_data_i(p_data), .p_addr_o(p_addr),
        .r_data_i(r_rdata), .r_data_o(r_wdata), .r_addr_o(r_addr), .r_we_o(r_we)
    );

    bind nkmd_cpu nkmd_cpu_asserts asserts_inst (
        .clk(clk), .rst(rst), .hold_i(hold), .n_val_i(n_val),
        .p_addr_i(p_addr_o), .r_we_i(r_we_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Asynchronous program ROM, no-ops past the end of the program
    assign p_data = (p_addr < prog_len) ? golden[p_addr[7:0]] : '0;

    // Synchronous data RAM
    always @(posedge clk) begin
        if (r_we) begin
            ram[r_addr[3:0]] <= r_wdata;
        end
        r_rdata <= ram[r_addr[3:0]];
    end

    function automatic string test_name(input int num);
        string name;
        case (num)
            1: name = "alu_ops";
            2: name = "load_operand";
            3: name = "store_address";
            4: name = "jump_delay";
            5: name = "repeat_count";
            default: name = "unknown";
        endcase
        return name;
    endfunction

    task automatic check_value(input int test, input string field,
                               input logic [nkmd_pkg::DATA_W-1:0] expected,
                               input logic [nkmd_pkg::DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected 0x%08h, actual 0x%08h",
                     test_name(test), field, expected, actual);
            errors++;
            test_errors[test]++;
        end
    endtask

    task automatic report_test(input int test);
        if (test_errors[test] == 0) begin
            $display("test %s passed", test_name(test));
            tests_passed++;
        end else begin
            $display("test %s failed with %0d mismatches", test_name(test), test_errors[test]);
            tests_failed++;
        end
    endtask

    // Every store is matched in order against the expected list
    always @(posedge clk) begin
        if (!rst && r_we) begin
            if (store_idx >= store_cnt) begin
                $display("error: unexpected store of 0x%08h to address 0x%08h",
                         r_wdata, r_addr);
                errors++;
            end else begin
                entry = STORE_BASE + 3 * store_idx;
                cur_test = golden[entry];
                check_value(cur_test, "address", golden[entry + 1], r_addr);
                check_value(cur_test, "data", golden[entry + 2], r_wdata);
                store_idx++;
                if (store_idx == store_cnt || golden[entry + 3] != cur_test) begin
                    report_test(cur_test);
                end
            end
        end
    end

    initial begin
        rst <= 1'b1;
        r_rdata <= '0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        store_idx = 0;
        for (int i = 1; i <= TEST_COUNT; i++) begin
            test_errors[i] = 0;
        end
        $readmemh("bench/nkmd_cpu_golden.hex", golden);
        prog_len = golden[INFO_BASE];
        store_cnt = golden[INFO_BASE + 1];
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] <= golden[RAM_BASE + i];
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        cycles = 0;
        while (store_idx < store_cnt && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (store_idx < store_cnt) begin
            $display("timeout: the CPU stopped storing after %0d of %0d expected stores",
                     store_idx, store_cnt);
            errors++;
        end else begin
            // Stray stores after the list are caught by the monitor
            cycles = 0;
            while (cycles < DRAIN_CYCLES) begin
                @(posedge clk);
                cycles++;
            end
        end

        errors += nkmd_cpu_inst.asserts_inst.fail_count;

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/nkmd_cpu_golden.hex
// Program words from @00, RAM image from @40, program length and store count at @50
// Expected stores from @52, one per line: test number, address, data
@00
0101000C 0201FFFA 05010005 06010006 07010007
08010009 0A01000A 09010028 25020200 25220200
25420200 25620200 25820200 25A20200 25C20200
25E20200 00000000 00000000 36030003 00000000
00000000 36000700 28010055 20010077 891280F6
200100D1 200100D2 200100D3 200100EE 200100EF
0E010003 00000000 00000000 2A1C1000 2A1C0000
@40
0000A000 0000A001 0000A002 12340000 0000A004 0000A005 0000A006 00ABCDEF
0000A008 0000A009 0000A00A 0000A00B 0000A00C 0000A00D 0000A00E 0000A00F
@50
00000023 00000014
// alu_ops: 12 op -6 stored at address 5
00000001 00000005 00000006
00000001 00000005 00000012
00000001 00000005 FFFFFFFE
00000001 00000005 00000008
00000001 00000005 FFFFFFF6
00000001 00000005 00000000
00000001 00000005 00000000
00000001 00000005 00000000
// load_operand
00000002 00000006 1234000C
00000002 00000006 00ABCDEF
// store_address
00000003 00000009 00000055
00000003 00000000 00000077
// jump_delay: only the three delay slots
00000004 00000000 000000D1
00000004 00000000 000000D2
00000004 00000000 000000D3
// repeat_count: n read by each issue, then n after the repeat
00000005 0000000A 00000003
00000005 0000000A 00000002
00000005 0000000A 00000001
00000005 0000000A 00000000
00000005 0000000A 00000000

//--- nkmd_cpu.f
hw/nkmd_pkg.sv
hw/nkmd_fetch_decode.sv
hw/nkmd_regfile.sv
hw/nkmd_repeat_counter.sv
hw/nkmd_operand_stage.sv
hw/nkmd_execute.sv
hw/nkmd_cpu.sv
bench/nkmd_cpu_asserts.sv
bench/nkmd_cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module nkmd_cpu_tb -f nkmd_cpu.f \
    && ./obj_dir/Vnkmd_cpu_tb | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
